/* rv_core_pkg.sv */
/*
 * Shared types for the multi-cycle RV32I core: opcode, ALU, writeback
 * and sequencer state enums, the decoded control bundle and APB structs
 */
package rv_core_pkg;

    localparam int XLEN = 32;

    // RV32I major opcodes kept by this core
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        IMMED  = 7'b0010011,
        REGREG = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        W_SEL_FROM_ALU,
        W_SEL_FROM_DLOAD,
        W_SEL_FROM_PC,
        W_SEL_FROM_IMM_U
    } w_sel_e;

    typedef enum logic [2:0] {
        FETCH_SETUP,
        FETCH_ACCESS,
        EXECUTE,
        MEM_SETUP,
        MEM_ACCESS,
        WRITEBACK,
        HALTED
    } seq_state_e;

    // Decoded instruction, 51 bits
    typedef struct packed {
        alu_op_e         alu_op;
        logic            alu_a_sel;    // 1 selects PC
        logic            alu_b_sel;    // 1 selects immediate
        logic [XLEN-1:0] imm;
        w_sel_e          w_sel;
        logic            wen;
        logic            dren;
        logic            dwen;
        logic            branch;
        logic [2:0]      branch_type;
        logic            jump;
        logic            j_sel;        // JAL rather than JALR
        logic            halt;
        logic            illegal_insn;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] paddr;
        logic            pwrite;
        logic [XLEN-1:0] pwdata;
        logic            psel;
        logic            penable;
    } apb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

endpackage

/* control_unit.sv */
/*
 * Instruction decoder: register selects, immediate generation and
 * the control bundle for the sequencer and datapath
 */
module control_unit (
    input  logic [31:0]        instr_i,
    output rv_core_pkg::ctrl_t ctrl_o,
    output logic [4:0]         rs1_o,
    output logic [4:0]         rs2_o,
    output logic [4:0]         rd_o
);
    rv_core_pkg::opcode_e opcode;
    rv_core_pkg::alu_op_e alu_op;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_sb;
    logic [31:0] imm_uj;
    logic [31:0] imm_u;
    logic        is_regreg;
    logic        arith;

    assign opcode = rv_core_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign rd_o   = instr_i[11:7];

    // Sign-extended immediates per format
    assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
    assign imm_uj = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};
    assign imm_u  = {instr_i[31:12], 12'b0};

    assign is_regreg = (opcode == rv_core_pkg::REGREG);
    assign arith     = is_regreg || (opcode == rv_core_pkg::IMMED);

    // Shifts first, then add and sub, then logic and compares
    always_comb begin
        if (arith && funct3 == 3'b001) alu_op = rv_core_pkg::ALU_SLL;
        else if (arith && funct3 == 3'b101 && instr_i[30]) alu_op = rv_core_pkg::ALU_SRA;
        else if (arith && funct3 == 3'b101) alu_op = rv_core_pkg::ALU_SRL;
        else if (is_regreg && funct3 == 3'b000 && instr_i[30]) alu_op = rv_core_pkg::ALU_SUB;
        else if (arith && funct3 == 3'b111) alu_op = rv_core_pkg::ALU_AND;
        else if (arith && funct3 == 3'b110) alu_op = rv_core_pkg::ALU_OR;
        else if (arith && funct3 == 3'b100) alu_op = rv_core_pkg::ALU_XOR;
        else if (arith && funct3 == 3'b010) alu_op = rv_core_pkg::ALU_SLT;
        else if (arith && funct3 == 3'b011) alu_op = rv_core_pkg::ALU_SLTU;
        else alu_op = rv_core_pkg::ALU_ADD;    // addi, add, address and AUIPC sums
    end

    always_comb begin
        ctrl_o             = '0;
        ctrl_o.alu_op      = alu_op;
        ctrl_o.branch_type = funct3;
        ctrl_o.w_sel       = rv_core_pkg::W_SEL_FROM_ALU;
        ctrl_o.halt        = (instr_i == 32'h0000006f);
        case (opcode)
            rv_core_pkg::REGREG: begin
                ctrl_o.wen          = 1'b1;
                ctrl_o.illegal_insn = (funct7 != 7'h00) && (funct7 != 7'h20);
            end
            rv_core_pkg::IMMED: begin
                ctrl_o.alu_b_sel = 1'b1;
                ctrl_o.imm       = imm_i;
                ctrl_o.wen       = 1'b1;
            end
            rv_core_pkg::LOAD: begin
                ctrl_o.alu_b_sel = 1'b1;
                ctrl_o.imm       = imm_i;
                ctrl_o.wen       = 1'b1;
                ctrl_o.dren      = 1'b1;
                ctrl_o.w_sel     = rv_core_pkg::W_SEL_FROM_DLOAD;
            end
            rv_core_pkg::STORE: begin
                ctrl_o.alu_b_sel = 1'b1;
                ctrl_o.imm       = imm_s;
                ctrl_o.dwen      = 1'b1;
            end
            rv_core_pkg::BRANCH: begin
                ctrl_o.imm    = imm_sb;
                ctrl_o.branch = 1'b1;
            end
            rv_core_pkg::JAL: begin
                ctrl_o.imm   = imm_uj;
                ctrl_o.jump  = 1'b1;
                ctrl_o.j_sel = 1'b1;
                ctrl_o.wen   = 1'b1;
                ctrl_o.w_sel = rv_core_pkg::W_SEL_FROM_PC;
            end
            rv_core_pkg::JALR: begin
                // Target is rs1 + imm through the ALU
                ctrl_o.alu_b_sel = 1'b1;
                ctrl_o.imm       = imm_i;
                ctrl_o.jump      = 1'b1;
                ctrl_o.wen       = 1'b1;
                ctrl_o.w_sel     = rv_core_pkg::W_SEL_FROM_PC;
            end
            rv_core_pkg::LUI: begin
                ctrl_o.imm   = imm_u;
                ctrl_o.wen   = 1'b1;
                ctrl_o.w_sel = rv_core_pkg::W_SEL_FROM_IMM_U;
            end
            rv_core_pkg::AUIPC: begin
                ctrl_o.alu_a_sel = 1'b1;
                ctrl_o.alu_b_sel = 1'b1;
                ctrl_o.imm       = imm_u;
                ctrl_o.wen       = 1'b1;
            end
            default: ctrl_o.illegal_insn = 1'b1;
        endcase
    end

endmodule

/* rv_alu.sv */
/*
 * RV32I ALU with the six-way branch comparator
 */
module rv_alu (
    input  rv_core_pkg::alu_op_e         op_i,
    input  logic [rv_core_pkg::XLEN-1:0] a_i,
    input  logic [rv_core_pkg::XLEN-1:0] b_i,
    input  logic [2:0]                   branch_type_i,
    output logic [rv_core_pkg::XLEN-1:0] result_o,
    output logic                         take_o
);
    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            rv_core_pkg::ALU_SUB:  result_o = a_i - b_i;
            rv_core_pkg::ALU_SLL:  result_o = a_i << shamt;
            rv_core_pkg::ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            rv_core_pkg::ALU_SLTU: result_o = {31'b0, a_i < b_i};
            rv_core_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            rv_core_pkg::ALU_SRL:  result_o = a_i >> shamt;
            rv_core_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            rv_core_pkg::ALU_OR:   result_o = a_i | b_i;
            rv_core_pkg::ALU_AND:  result_o = a_i & b_i;
            default:               result_o = a_i + b_i;
        endcase
    end

    // funct3 of the branch picks the compare
    always_comb begin
        case (branch_type_i)
            3'b000:  take_o = (a_i == b_i);
            3'b001:  take_o = (a_i != b_i);
            3'b100:  take_o = $signed(a_i) < $signed(b_i);
            3'b101:  take_o = $signed(a_i) >= $signed(b_i);
            3'b110:  take_o = a_i < b_i;
            3'b111:  take_o = a_i >= b_i;
            default: take_o = 1'b0;
        endcase
    end

endmodule

/* rv_reg_file.sv */
/*
 * 32 x 32 register file, two combinational reads, one clocked write
 */
module rv_reg_file (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic [4:0]                   rs1_i,
    input  logic [4:0]                   rs2_i,
    input  logic [4:0]                   rd_i,
    input  logic                         wen_i,
    input  logic [rv_core_pkg::XLEN-1:0] wdata_i,
    output logic [rv_core_pkg::XLEN-1:0] rdata1_o,
    output logic [rv_core_pkg::XLEN-1:0] rdata2_o
);
    logic [rv_core_pkg::XLEN-1:0] regs [32];

    // Entry 0 is cleared by reset and never written
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && rd_i != 5'd0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = regs[rs1_i];
    assign rdata2_o = regs[rs2_i];

    a_x0_holds: assert property (@(posedge clk_i) disable iff (reset_i)
        (wen_i && rd_i == 5'd0) |=> (rs1_i != 5'd0 || rdata1_o == '0));

endmodule

/* core_sequencer.sv */
/*
 * Instruction sequencer FSM with PC, instruction and load data registers,
 * the APB master and the writeback mux
 */
module core_sequencer #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  rv_core_pkg::apb_rsp_t        apb_rsp_i,
    input  rv_core_pkg::ctrl_t           ctrl_i,
    input  logic [rv_core_pkg::XLEN-1:0] rdata1_i,
    input  logic [rv_core_pkg::XLEN-1:0] rdata2_i,
    input  logic [rv_core_pkg::XLEN-1:0] alu_result_i,
    input  logic                         take_i,
    output rv_core_pkg::apb_req_t        apb_req_o,
    output logic [31:0]                  instr_o,
    output logic [rv_core_pkg::XLEN-1:0] alu_a_o,
    output logic [rv_core_pkg::XLEN-1:0] alu_b_o,
    output logic                         rf_wen_o,
    output logic [rv_core_pkg::XLEN-1:0] rf_wdata_o,
    output logic                         retire_o,
    output logic                         halted_o,
    output logic                         illegal_o
);
    rv_core_pkg::seq_state_e      state;
    rv_core_pkg::seq_state_e      state_next;
    rv_core_pkg::apb_req_t        req_next;
    logic [rv_core_pkg::XLEN-1:0] pc;
    logic [rv_core_pkg::XLEN-1:0] pc_next;
    logic [rv_core_pkg::XLEN-1:0] pc_plus4;
    logic [31:0]                  ir;
    logic [rv_core_pkg::XLEN-1:0] ldata;
    logic                         done;
    logic                         fault;
    logic                         mem_phase;
    logic                         illegal_q;

    // Transfer completes on this edge
    assign done     = apb_req_o.psel && apb_req_o.penable && apb_rsp_i.pready;
    assign fault    = done && apb_rsp_i.pslverr;
    assign pc_plus4 = pc + 32'd4;

    // PC moves only at writeback
    always_comb begin
        pc_next = pc;
        if (state == rv_core_pkg::WRITEBACK) begin
            if (ctrl_i.jump && ctrl_i.j_sel) pc_next = pc + ctrl_i.imm;
            else if (ctrl_i.jump) pc_next = {alu_result_i[31:1], 1'b0};
            else if (ctrl_i.branch && take_i) pc_next = pc + ctrl_i.imm;
            else pc_next = pc_plus4;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            // Stays one cycle after reset until psel is up
            rv_core_pkg::FETCH_SETUP: begin
                if (apb_req_o.psel) state_next = rv_core_pkg::FETCH_ACCESS;
            end
            rv_core_pkg::FETCH_ACCESS: begin
                if (fault) state_next = rv_core_pkg::HALTED;
                else if (done) state_next = rv_core_pkg::EXECUTE;
            end
            rv_core_pkg::EXECUTE: begin
                if (ctrl_i.illegal_insn || ctrl_i.halt) state_next = rv_core_pkg::HALTED;
                else if (ctrl_i.dren || ctrl_i.dwen) state_next = rv_core_pkg::MEM_SETUP;
                else state_next = rv_core_pkg::WRITEBACK;
            end
            rv_core_pkg::MEM_SETUP: state_next = rv_core_pkg::MEM_ACCESS;
            rv_core_pkg::MEM_ACCESS: begin
                if (fault) state_next = rv_core_pkg::HALTED;
                else if (done) state_next = rv_core_pkg::WRITEBACK;
            end
            rv_core_pkg::WRITEBACK: state_next = rv_core_pkg::FETCH_SETUP;
            default: state_next = rv_core_pkg::HALTED;
        endcase
    end

    // Bus request follows the state being entered
    always_comb begin
        mem_phase = (state_next == rv_core_pkg::MEM_SETUP) ||
                    (state_next == rv_core_pkg::MEM_ACCESS);
        req_next.psel    = mem_phase || (state_next == rv_core_pkg::FETCH_SETUP) ||
                           (state_next == rv_core_pkg::FETCH_ACCESS);
        req_next.penable = (state_next == rv_core_pkg::FETCH_ACCESS) ||
                           (state_next == rv_core_pkg::MEM_ACCESS);
        req_next.paddr   = mem_phase ? alu_result_i : pc_next;
        req_next.pwrite  = mem_phase && ctrl_i.dwen;
        req_next.pwdata  = req_next.pwrite ? rdata2_i : '0;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state     <= rv_core_pkg::FETCH_SETUP;
            apb_req_o <= '0;
            pc        <= RESET_PC;
            illegal_q <= 1'b0;
        end else begin
            state     <= state_next;
            apb_req_o <= req_next;
            pc        <= pc_next;
            if (fault || (state == rv_core_pkg::EXECUTE && ctrl_i.illegal_insn)) begin
                illegal_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == rv_core_pkg::FETCH_ACCESS && done) begin
            ir <= apb_rsp_i.prdata;
        end
        if (state == rv_core_pkg::MEM_ACCESS && done && !apb_req_o.pwrite) begin
            ldata <= apb_rsp_i.prdata;
        end
    end

    always_comb begin
        case (ctrl_i.w_sel)
            rv_core_pkg::W_SEL_FROM_DLOAD: rf_wdata_o = ldata;
            rv_core_pkg::W_SEL_FROM_PC:    rf_wdata_o = pc_plus4;
            rv_core_pkg::W_SEL_FROM_IMM_U: rf_wdata_o = ctrl_i.imm;
            default:                       rf_wdata_o = alu_result_i;
        endcase
    end

    assign instr_o   = ir;
    assign alu_a_o   = ctrl_i.alu_a_sel ? pc : rdata1_i;
    assign alu_b_o   = ctrl_i.alu_b_sel ? ctrl_i.imm : rdata2_i;
    assign rf_wen_o  = (state == rv_core_pkg::WRITEBACK) && ctrl_i.wen;
    assign retire_o  = (state == rv_core_pkg::WRITEBACK);
    assign halted_o  = (state == rv_core_pkg::HALTED);
    assign illegal_o = illegal_q;

    a_penable_psel: assert property (@(posedge clk_i) disable iff (reset_i)
        apb_req_o.penable |-> apb_req_o.psel);

    a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (apb_req_o.penable && !apb_rsp_i.pready) |=> $stable(apb_req_o));

    // Halted is final and retires nothing
    a_halt_final: assert property (@(posedge clk_i) disable iff (reset_i)
        halted_o |=> (halted_o && !retire_o));

endmodule

/* retire_counter.sv */
/*
 * Retired instruction counter
 */
module retire_counter (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        retire_i,
    output logic [31:0] instret_o
);
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instret_o <= '0;
        end else if (retire_i) begin
            instret_o <= instret_o + 32'd1;
        end
    end

endmodule

/* rv_core_top.sv */
/*
 * Core top level: sequencer, decoder, register file, ALU and retire counter
 */
module rv_core_top #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    output rv_core_pkg::apb_req_t apb_req_o,
    input  rv_core_pkg::apb_rsp_t apb_rsp_i,
    output logic                  halted_o,
    output logic                  illegal_o,
    output logic [31:0]           instret_o
);
    rv_core_pkg::ctrl_t           ctrl;
    logic [31:0]                  instr;
    logic [4:0]                   rs1;
    logic [4:0]                   rs2;
    logic [4:0]                   rd;
    logic [rv_core_pkg::XLEN-1:0] rdata1;
    logic [rv_core_pkg::XLEN-1:0] rdata2;
    logic [rv_core_pkg::XLEN-1:0] alu_a;
    logic [rv_core_pkg::XLEN-1:0] alu_b;
    logic [rv_core_pkg::XLEN-1:0] alu_result;
    logic [rv_core_pkg::XLEN-1:0] rf_wdata;
    logic                         take;
    logic                         rf_wen;
    logic                         retire;

    core_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_seq (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .apb_rsp_i    (apb_rsp_i),
        .ctrl_i       (ctrl),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .alu_result_i (alu_result),
        .take_i       (take),
        .apb_req_o    (apb_req_o),
        .instr_o      (instr),
        .alu_a_o      (alu_a),
        .alu_b_o      (alu_b),
        .rf_wen_o     (rf_wen),
        .rf_wdata_o   (rf_wdata),
        .retire_o     (retire),
        .halted_o     (halted_o),
        .illegal_o    (illegal_o)
    );

    control_unit u_cu (
        .instr_i (instr),
        .ctrl_o  (ctrl),
        .rs1_o   (rs1),
        .rs2_o   (rs2),
        .rd_o    (rd)
    );

    rv_reg_file u_rf (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .rd_i     (rd),
        .wen_i    (rf_wen),
        .wdata_i  (rf_wdata),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    rv_alu u_alu (
        .op_i          (ctrl.alu_op),
        .a_i           (alu_a),
        .b_i           (alu_b),
        .branch_type_i (ctrl.branch_type),
        .result_o      (alu_result),
        .take_o        (take)
    );

    retire_counter u_ret (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .retire_i  (retire),
        .instret_o (instret_o)
    );

endmodule

/* tb_rv_core.sv */
/*
 * Testbench for the RV32I core: clock, reset, APB memory model with random
 * wait states, program images and checking assertions
 */
module tb_rv_core;

    logic                  clk_i;
    logic                  reset_i;
    rv_core_pkg::apb_req_t apb_req;
    rv_core_pkg::apb_rsp_t apb_rsp;
    logic                  halted_o;
    logic                  illegal_o;
    logic [31:0]           instret_o;

    logic [31:0] mem [256];
    logic [31:0] exp_val [256];
    bit          exp_valid [256];
    bit          exp_seen [256];
    int          exp_grp [256];
    string       grp_name [6] = '{"arith", "memory", "flow", "halt", "illegal", "apb"};
    int          grp_checks [6] = '{default: 0};
    int          grp_err [6] = '{default: 0};
    logic [31:0] prog_pc;
    logic [31:0] last_raddr;
    int          on_path;
    int          slot;
    int          run_grp;
    int          halt_grp;
    int          transfers = 0;
    int          wait_left;
    int          waits;
    integer      seed;
    logic        wr_done;
    logic [7:0]  widx;

    rv_core_top #(
        .RESET_PC (32'h0)
    ) dut0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .apb_req_o (apb_req),
        .apb_rsp_i (apb_rsp),
        .halted_o  (halted_o),
        .illegal_o (illegal_o),
        .instret_o (instret_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    assign wr_done = apb_req.psel && apb_req.penable && apb_rsp.pready && apb_req.pwrite;
    assign widx    = apb_req.paddr[9:2];

    // APB slave over a word array with 0 to 3 wait cycles per transfer
    always @(posedge clk_i) begin
        if (reset_i) begin
            apb_rsp   <= '0;
            wait_left <= 0;
        end else if (apb_req.psel && !apb_req.penable) begin
            waits = $random(seed) & 3;
            wait_left      <= waits;
            apb_rsp.pready <= (waits == 0);
            apb_rsp.prdata <= mem[apb_req.paddr[9:2]];
        end else if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
            if (apb_req.pwrite) begin
                mem[apb_req.paddr[9:2]] = apb_req.pwdata;
                exp_seen[apb_req.paddr[9:2]] = 1'b1;
            end else begin
                last_raddr <= apb_req.paddr;
            end
            transfers = transfers + 1;
            apb_rsp.pready <= 1'b0;
        end else if (apb_req.psel) begin
            wait_left      <= wait_left - 1;
            apb_rsp.pready <= (wait_left == 1);
        end else begin
            apb_rsp.pready <= 1'b0;
        end
    end

    a_store_known: assert property (@(posedge clk_i) disable iff (reset_i)
        wr_done |-> exp_valid[widx])
        else begin
            $display("Write of %h to unexpected address %h",
                     $sampled(apb_req.pwdata), $sampled(apb_req.paddr));
            grp_err[run_grp]++;
        end

    a_store_value: assert property (@(posedge clk_i) disable iff (reset_i)
        (wr_done && exp_valid[widx]) |-> (apb_req.pwdata == exp_val[widx]))
        else begin
            $display("ERR %s@%h expected %h actual %h", grp_name[exp_grp[$sampled(widx)]],
                     $sampled(apb_req.paddr), exp_val[$sampled(widx)],
                     $sampled(apb_req.pwdata));
            grp_err[exp_grp[$sampled(widx)]]++;
        end

    // Fetch and data addresses stay word aligned
    a_word_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        apb_req.psel |-> (apb_req.paddr[1:0] == 2'b00))
        else begin
            $display("APB address %h is not word aligned", $sampled(apb_req.paddr));
            grp_err[run_grp]++;
        end

    a_setup_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(apb_req.penable) |-> $past(apb_req.psel))
        else begin
            $display("APB penable rose without a setup cycle");
            grp_err[5]++;
        end

    a_hold_request: assert property (@(posedge clk_i) disable iff (reset_i)
        (apb_req.penable && !apb_rsp.pready) |=> $stable(apb_req))
        else begin
            $display("APB request changed before pready");
            grp_err[5]++;
        end

    a_halt_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
        halted_o |-> !apb_req.psel)
        else begin
            $display("Bus select raised while the core is halted");
            grp_err[halt_grp]++;
        end

    a_illegal_halts: assert property (@(posedge clk_i) disable iff (reset_i)
        illegal_o |-> halted_o)
        else begin
            $display("illegal_o is set but the core is not halted");
            grp_err[halt_grp]++;
        end

    // Instruction encoders
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic place_word(input logic [31:0] insn);
        mem[prog_pc[9:2]] = insn;
        prog_pc = prog_pc + 32'd4;
    endtask

    // Instruction on the executed path, counted for instret
    task automatic emit_insn(input logic [31:0] insn);
        place_word(insn);
        on_path++;
    endtask

    task automatic expect_word(input int idx, input logic [31:0] v, input int g);
        exp_val[idx]   = v;
        exp_valid[idx] = 1'b1;
        exp_grp[idx]   = g;
        grp_checks[g]++;
    endtask

    // Result slots start at 0x200 and x1 holds the base
    task automatic store_check(input logic [4:0] rd, input logic [31:0] v, input int g);
        int idx;
        idx = 128 + slot;
        emit_insn(enc_s(12'(slot * 4), rd, 5'd1));
        expect_word(idx, v, g);
        slot++;
    endtask

    task automatic op_and_store(input logic [31:0] insn, input logic [4:0] rd,
                                input logic [31:0] v, input int g);
        emit_insn(insn);
        store_check(rd, v, g);
    endtask

    // Taken skips a stray store and not taken falls into the marker
    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input bit taken,
                               input logic [11:0] mark);
        if (taken) begin
            emit_insn(enc_b(13'd8, rs2, rs1, f3));
            place_word(enc_s(12'h1F0, 5'd2, 5'd1));
        end else begin
            emit_insn(enc_b(13'd12, rs2, rs1, f3));
        end
        op_and_store(enc_i(mark, 5'd0, 3'b000, 5'd24, 7'h13), 5'd24, {20'b0, mark}, 2);
    endtask

    task automatic clear_image();
        for (int i = 0; i < 256; i++) begin
            mem[i]       = {16'(i), ~16'(i)};
            exp_val[i]   = '0;
            exp_valid[i] = 1'b0;
            exp_seen[i]  = 1'b0;
            exp_grp[i]   = 0;
        end
        prog_pc = '0;
        on_path = 0;
        slot    = 0;
    endtask

    task automatic build_main_image();
        logic [31:0] at_pc;
        emit_insn(enc_i(12'h200, 5'd0, 3'b000, 5'd1, 7'h13));
        emit_insn(enc_i(12'd100, 5'd0, 3'b000, 5'd2, 7'h13));
        op_and_store(enc_i(12'hFF9, 5'd0, 3'b000, 5'd3, 7'h13), 3, 32'hFFFFFFF9, 0);
        op_and_store(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd4), 4, 32'h0000005D, 0);
        op_and_store(enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd5), 5, 32'hFFFFFF95, 0);
        op_and_store(enc_r(7'h00, 5'd2, 5'd3, 3'b001, 5'd6), 6, 32'hFFFFFF90, 0);
        op_and_store(enc_i({7'h00, 5'd3}, 5'd2, 3'b001, 5'd7, 7'h13), 7, 32'h00000320, 0);
        op_and_store(enc_r(7'h00, 5'd2, 5'd3, 3'b101, 5'd8), 8, 32'h0FFFFFFF, 0);
        op_and_store(enc_i({7'h00, 5'd28}, 5'd3, 3'b101, 5'd9, 7'h13), 9, 32'h0000000F, 0);
        op_and_store(enc_r(7'h20, 5'd2, 5'd3, 3'b101, 5'd10), 10, 32'hFFFFFFFF, 0);
        op_and_store(enc_i({7'h20, 5'd5}, 5'd7, 3'b101, 5'd11, 7'h13), 11, 32'h00000019, 0);
        op_and_store(enc_r(7'h00, 5'd2, 5'd3, 3'b010, 5'd12), 12, 32'h00000001, 0);
        op_and_store(enc_r(7'h00, 5'd2, 5'd3, 3'b011, 5'd13), 13, 32'h00000000, 0);
        op_and_store(enc_i(12'hFFF, 5'd2, 3'b011, 5'd14, 7'h13), 14, 32'h00000001, 0);
        op_and_store(enc_r(7'h00, 5'd3, 5'd2, 3'b100, 5'd15), 15, 32'hFFFFFF9D, 0);
        op_and_store(enc_i(12'h00F, 5'd2, 3'b100, 5'd16, 7'h13), 16, 32'h0000006B, 0);
        op_and_store(enc_r(7'h00, 5'd3, 5'd2, 3'b110, 5'd17), 17, 32'hFFFFFFFD, 0);
        op_and_store(enc_i(12'h103, 5'd2, 3'b110, 5'd18, 7'h13), 18, 32'h00000167, 0);
        op_and_store(enc_r(7'h00, 5'd3, 5'd2, 3'b111, 5'd19), 19, 32'h00000060, 0);
        op_and_store(enc_i(12'h7F0, 5'd3, 3'b111, 5'd20, 7'h13), 20, 32'h000007F0, 0);
        op_and_store({20'hABCDE, 5'd21, 7'h37}, 21, 32'hABCDE000, 0);
        op_and_store({20'h00001, 5'd22, 7'h17}, 22, prog_pc + 32'h1000, 0);
        // Word round trip through 0x300 and then x0 as a destination
        emit_insn(enc_s(12'h100, 5'd17, 5'd1));
        expect_word(192, 32'hFFFFFFFD, 1);
        op_and_store(enc_i(12'h100, 5'd1, 3'b010, 5'd23, 7'h03), 23, 32'hFFFFFFFD, 1);
        op_and_store(enc_i(12'd5, 5'd2, 3'b000, 5'd0, 7'h13), 0, 32'h0, 1);
        op_and_store(enc_i(12'h100, 5'd1, 3'b010, 5'd0, 7'h03), 0, 32'h0, 1);
        // x2 is 100 and x3 is -7
        branch_case(3'b000, 5'd2, 5'd2, 1'b1, 12'h101);
        branch_case(3'b000, 5'd2, 5'd3, 1'b0, 12'h102);
        branch_case(3'b001, 5'd2, 5'd3, 1'b1, 12'h103);
        branch_case(3'b001, 5'd2, 5'd2, 1'b0, 12'h104);
        branch_case(3'b100, 5'd3, 5'd2, 1'b1, 12'h105);
        branch_case(3'b100, 5'd2, 5'd3, 1'b0, 12'h106);
        branch_case(3'b101, 5'd2, 5'd3, 1'b1, 12'h107);
        branch_case(3'b101, 5'd3, 5'd2, 1'b0, 12'h108);
        branch_case(3'b110, 5'd2, 5'd3, 1'b1, 12'h109);
        branch_case(3'b110, 5'd3, 5'd2, 1'b0, 12'h10A);
        branch_case(3'b111, 5'd3, 5'd2, 1'b1, 12'h10B);
        branch_case(3'b111, 5'd2, 5'd3, 1'b0, 12'h10C);
        at_pc = prog_pc;
        emit_insn(enc_j(21'd8, 5'd25));
        place_word(enc_s(12'h1F0, 5'd2, 5'd1));
        store_check(25, at_pc + 32'd4, 2);
        // Odd JALR offset so target bit 0 must be cleared
        at_pc = prog_pc;
        emit_insn({20'h0, 5'd26, 7'h17});
        emit_insn(enc_i(12'd13, 5'd26, 3'b000, 5'd27, 7'h67));
        place_word(enc_s(12'h1F0, 5'd2, 5'd1));
        store_check(27, at_pc + 32'd8, 2);
        place_word(32'h0000006f);
    endtask

    // Undefined opcode at 0x0C with a store behind it that must never run
    task automatic build_illegal_image();
        emit_insn(enc_i(12'h200, 5'd0, 3'b000, 5'd1, 7'h13));
        op_and_store(enc_i(12'd55, 5'd0, 3'b000, 5'd2, 7'h13), 2, 32'd55, 4);
        place_word(32'hFFFFFFFF);
        place_word(enc_s(12'd4, 5'd2, 5'd1));
    endtask

    task automatic wait_halted(input int g);
        int n;
        n = 0;
        while (!halted_o && n < 5000) begin
            @(negedge clk_i);
            n++;
        end
        if (!halted_o) begin
            $display("Timeout: core did not halt within 5000 cycles");
            grp_err[g]++;
        end
    endtask

    task automatic watch_bus_idle(input int g);
        int busy;
        busy = 0;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk_i);
            if (apb_req.psel) busy++;
        end
        grp_checks[g]++;
        if (busy != 0) begin
            $display("Bus still active after halt in %0d of 20 cycles", busy);
            grp_err[g]++;
        end
    endtask

    task automatic check_missing_stores();
        for (int i = 0; i < 256; i++) begin
            if (exp_valid[i] && !exp_seen[i]) begin
                $display("Missing store for test %s at address %h", grp_name[exp_grp[i]],
                         32'(i * 4));
                grp_err[exp_grp[i]]++;
            end
        end
    endtask

    task automatic report_test(input int g);
        $display("test %-8s %0d checks, %0d errors", grp_name[g], grp_checks[g], grp_err[g]);
    endtask

    initial begin
        int total_checks;
        int total_errs;
        seed = 32'hda54c6a4;
        apb_rsp <= '0;
        reset_i <= 1'b1;
        run_grp  = 2;
        halt_grp = 3;
        clear_image();
        build_main_image();
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;
        wait_halted(3);
        check_missing_stores();
        report_test(0);
        report_test(1);
        report_test(2);
        grp_checks[3] += 2;
        if (illegal_o) begin
            $display("illegal_o set after the halt instruction");
            grp_err[3]++;
        end
        if (instret_o !== 32'(on_path)) begin
            $display("ERR halt_instret expected %0d actual %0d", on_path, instret_o);
            grp_err[3]++;
        end
        watch_bus_idle(3);
        report_test(3);

        // Second run with an undefined opcode
        @(posedge clk_i);
        reset_i <= 1'b1;
        run_grp  = 4;
        halt_grp = 4;
        clear_image();
        build_illegal_image();
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;
        wait_halted(4);
        check_missing_stores();
        grp_checks[4] += 3;
        if (!illegal_o) begin
            $display("illegal_o not set after the undefined opcode");
            grp_err[4]++;
        end
        if (last_raddr !== 32'h0000000C) begin
            $display("ERR illegal_addr expected %h actual %h", 32'h0000000C, last_raddr);
            grp_err[4]++;
        end
        if (instret_o !== 32'(on_path)) begin
            $display("ERR illegal_instret expected %0d actual %0d", on_path, instret_o);
            grp_err[4]++;
        end
        watch_bus_idle(4);
        report_test(4);
        grp_checks[5] = transfers;
        report_test(5);

        total_checks = 0;
        total_errs   = 0;
        for (int g = 0; g < 6; g++) begin
            total_checks += grp_checks[g];
            total_errs   += grp_err[g];
        end
        $display("tests 6, checks %0d, errors %0d", total_checks, total_errs);
        if (total_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* build.f */
rv_core_pkg.sv
control_unit.sv
rv_alu.sv
rv_reg_file.sv
core_sequencer.sv
retire_counter.sv
rv_core_top.sv
tb_rv_core.sv
